// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench under Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f sh_decode_top.f --top-module tb_sh_decode -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_sh_decode > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
	exit 1
fi
exit 0

// ==== sh_alu_dec.sv ====
`timescale 1ns/10ps

module sh_alu_dec
	import sh_dec_pkg::*;
(
	input  logic [INSTR_W-1:0]    cur_instr,
	input  logic [STEP_W-1:0]     step,
	input  logic                  step_valid,
	output alu_op_e               alu_op,
	output logic                  alu_sa,
	output logic                  alu_sb,
	output logic [ALU_CODE_W-1:0] alu_code,
	output logic [CMP_W-1:0]      alu_cmp,
	output logic                  t_write
);

	alu_op_e op;
	logic tw;
	logic first;

	assign first = (step == STEP_FIRST);

	always_comb begin
		op = ALU_NOP;
		{alu_sa, alu_sb} = 2'b00;
		alu_code = '0;
		alu_cmp = '0;
		tw = 1'b0;
		case (cur_instr[15:12])
			4'b0001, 4'b0111: begin	// Rn+disp, Rn+imm
				op = ALU_ADD;
				alu_sb = 1'b1;
			end
			4'b0010: begin
				case (cur_instr[3:0])
					4'b0000, 4'b0001, 4'b0010: begin	// Address is Rn+0
						op = ALU_ADD;
						alu_sb = 1'b1;
					end
					4'b1000: begin	// TST
						op = ALU_LOG;
						alu_code = ALU_CD_AND;
						tw = 1'b1;
					end
					4'b1001: begin
						op = ALU_LOG;
						alu_code = ALU_CD_AND;
					end
					4'b1010: begin
						op = ALU_LOG;
						alu_code = ALU_CD_XOR;
					end
					4'b1011: begin
						op = ALU_LOG;
						alu_code = ALU_CD_OR;
					end
					default: ;
				endcase
			end
			4'b0011: begin
				case (cur_instr[3:0])
					4'b0000, 4'b0010, 4'b0011, 4'b0110, 4'b0111: begin
						op = ALU_ADD;
						alu_code = ALU_CD_CMP;
						alu_cmp = cur_instr[2:0];
						tw = 1'b1;
					end
					4'b1000, 4'b1010, 4'b1100, 4'b1110: begin	// Bit 0 is subtract
						op = ALU_ADD;
						alu_code = {cur_instr[1:0], cur_instr[1] & ~cur_instr[0], ~cur_instr[2]};
						tw = cur_instr[1];	// With carry
					end
					default: ;
				endcase
			end
			4'b0100: begin
				case (cur_instr[7:0])
					8'h00, 8'h01, 8'h04, 8'h05, 8'h20, 8'h21: begin	// Single bit shifts into T
						op = ALU_SHIFT;
						alu_code = {1'b0, cur_instr[2], cur_instr[5], cur_instr[0]};
						tw = 1'b1;
					end
					8'h08, 8'h09, 8'h18, 8'h19, 8'h28, 8'h29: begin
						op = ALU_SHIFT;
						alu_code = {1'b1, cur_instr[5], cur_instr[4], cur_instr[0]};
					end
					8'h0b, 8'h2b: begin
						if (first) begin	// Target is Rm+0
							op = ALU_ADD;
							alu_sb = 1'b1;
						end
					end
					default: ;
				endcase
			end
			4'b0101: begin
				op = ALU_ADD;
				alu_sa = 1'b1;
			end
			4'b0110: begin
				case (cur_instr[3:0])
					4'b0000, 4'b0001, 4'b0010, 4'b0011: begin
						op = ALU_ADD;
						alu_sa = 1'b1;
					end
					4'b0111: begin	// 0|~Rm
						op = ALU_LOG;
						alu_sa = 1'b1;
						alu_code = ALU_CD_NOT;
					end
					4'b1010, 4'b1011: begin	// NEGC, NEG
						op = ALU_ADD;
						alu_sa = 1'b1;
						alu_code = {~cur_instr[0], 1'b0, ~cur_instr[0], 1'b1};
						tw = ~cur_instr[0];
					end
					4'b1000, 4'b1001, 4'b1100, 4'b1101, 4'b1110, 4'b1111: begin
						op = ALU_EXT;
						alu_code = {1'b0, cur_instr[2:0]};
					end
					default: ;
				endcase
			end
			4'b1000, 4'b1010, 4'b1011: begin
				if (first && (cur_instr[15:13] == 3'b101 || (cur_instr[11] && cur_instr[8]))) begin
					op = ALU_ADD;	// PC+disp
					alu_sa = 1'b1;
				end
			end
			4'b1100: begin
				if (cur_instr[11:10] == 2'b10) begin
					op = ALU_LOG;
					alu_sb = 1'b1;
					case (cur_instr[9:8])
						2'b10: alu_code = ALU_CD_XOR;
						2'b11: alu_code = ALU_CD_OR;
						default: alu_code = ALU_CD_AND;
					endcase
					tw = (cur_instr[9:8] == 2'b00);	// TST #imm,R0
				end
			end
			4'b1110: begin	// Immediate passes through
				alu_sb = 1'b1;
			end
			default: ;
		endcase
	end

	assign alu_op = step_valid ? op : ALU_NOP;
	assign t_write = step_valid & tw;

endmodule

// ==== sh_dec_pkg.sv ====
package sh_dec_pkg;

	localparam int INSTR_W    = 16;
	localparam int REG_NUM_W  = 5;	// Top bit selects special regs
	localparam int STEP_W     = 3;
	localparam int ALU_CODE_W = 4;
	localparam int CMP_W      = 3;
	localparam int MEM_SZ_W   = 2;	// Byte 0, word 1, long 2

	localparam logic [REG_NUM_W-1:0] REG_R0 = 5'd0;
	localparam logic [REG_NUM_W-1:0] REG_PR = 5'd16;	// Procedure register

	localparam logic [STEP_W-1:0] STEP_FIRST   = 3'd0;
	localparam logic [STEP_W-1:0] STEP_LAST_BR = 3'd1;	// Branch plus delay step

	localparam logic [MEM_SZ_W-1:0] MEM_SZ_LONG = 2'd2;

	// Logic unit codes
	localparam logic [ALU_CODE_W-1:0] ALU_CD_AND = 4'b0000;
	localparam logic [ALU_CODE_W-1:0] ALU_CD_XOR = 4'b0010;
	localparam logic [ALU_CODE_W-1:0] ALU_CD_OR  = 4'b0100;
	localparam logic [ALU_CODE_W-1:0] ALU_CD_NOT = 4'b0101;

	// Adder in compare mode with cmp as condition
	localparam logic [ALU_CODE_W-1:0] ALU_CD_CMP = 4'b0101;

	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_LOG,
		ALU_SHIFT,
		ALU_EXT
	} alu_op_e;

	typedef enum logic [2:0] {
		IMM_ZERO,
		IMM_ONE,
		IMM_ZIMM4,	// Zero extended disp
		IMM_ZIMM8,
		IMM_SIMM8,
		IMM_SIMM12	// BRA/BSR target
	} imm_kind_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_UCB,	// Unconditional
		BR_CB,	// Conditional
		BR_DCB	// Delayed conditional
	} branch_kind_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_ACK
	} seq_state_e;

endpackage

// ==== sh_decode_top.f ====
+incdir+.
sh_dec_pkg.sv
sh_step_seq.sv
sh_operand_dec.sv
sh_alu_dec.sv
sh_flow_dec.sv
sh_decode_top.sv
tb_sh_decode.sv

// ==== sh_decode_top.sv ====
`timescale 1ns/10ps

module sh_decode_top
	import sh_dec_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [INSTR_W-1:0]    instr,
	input  logic                  t_flag,
	input  logic                  instr_req,
	output logic                  instr_ack,
	output logic                  step_valid,
	output logic [STEP_W-1:0]     step,
	output logic [REG_NUM_W-1:0]  ra_num,
	output logic                  ra_read,
	output logic                  ra_write,
	output logic [REG_NUM_W-1:0]  rb_num,
	output logic                  rb_read,
	output logic                  rb_write,
	output imm_kind_e             imm_kind,
	output alu_op_e               alu_op,
	output logic                  alu_sa,
	output logic                  alu_sb,
	output logic [ALU_CODE_W-1:0] alu_code,
	output logic [CMP_W-1:0]      alu_cmp,
	output logic                  t_write,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic [MEM_SZ_W-1:0]   mem_size,
	output logic                  pc_write,
	output branch_kind_e          branch_kind
);

	logic [INSTR_W-1:0] cur_instr;
	logic cur_t;
	logic [STEP_W-1:0] last_step;	// From flow decoder

	sh_step_seq u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_req  (instr_req),
		.instr      (instr),
		.t_flag     (t_flag),
		.last_step  (last_step),
		.instr_ack  (instr_ack),
		.step_valid (step_valid),
		.step       (step),
		.cur_instr  (cur_instr),
		.cur_t      (cur_t)
	);

	sh_operand_dec u_operand (
		.cur_instr  (cur_instr),
		.step       (step),
		.step_valid (step_valid),
		.ra_num     (ra_num),
		.ra_read    (ra_read),
		.ra_write   (ra_write),
		.rb_num     (rb_num),
		.rb_read    (rb_read),
		.rb_write   (rb_write),
		.imm_kind   (imm_kind)
	);

	sh_alu_dec u_alu (
		.cur_instr  (cur_instr),
		.step       (step),
		.step_valid (step_valid),
		.alu_op     (alu_op),
		.alu_sa     (alu_sa),
		.alu_sb     (alu_sb),
		.alu_code   (alu_code),
		.alu_cmp    (alu_cmp),
		.t_write    (t_write)
	);

	sh_flow_dec u_flow (
		.cur_instr   (cur_instr),
		.cur_t       (cur_t),
		.step        (step),
		.step_valid  (step_valid),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_size    (mem_size),
		.pc_write    (pc_write),
		.branch_kind (branch_kind),
		.last_step   (last_step)
	);

endmodule

// ==== sh_flow_dec.sv ====
`timescale 1ns/10ps

module sh_flow_dec
	import sh_dec_pkg::*;
(
	input  logic [INSTR_W-1:0]  cur_instr,
	input  logic                cur_t,
	input  logic [STEP_W-1:0]   step,
	input  logic                step_valid,
	output logic                mem_read,
	output logic                mem_write,
	output logic [MEM_SZ_W-1:0] mem_size,
	output logic                pc_write,
	output branch_kind_e        branch_kind,
	output logic [STEP_W-1:0]   last_step
);

	logic rd;
	logic wr;
	logic pcw;
	branch_kind_e br;
	logic first;
	logic taken;

	assign first = (step == STEP_FIRST);
	assign taken = (cur_t == ~cur_instr[9]);	// BT needs T=1, BF needs T=0

	always_comb begin
		rd = 1'b0;
		wr = 1'b0;
		mem_size = '0;
		pcw = 1'b0;
		br = BR_NONE;
		last_step = STEP_FIRST;
		case (cur_instr[15:12])
			4'b0000: begin
				if (cur_instr[11:0] == 12'h00b) begin	// RTS
					last_step = STEP_LAST_BR;
					pcw = first;
					br = first ? BR_UCB : BR_NONE;
				end
			end
			4'b0001: begin
				wr = 1'b1;
				mem_size = MEM_SZ_LONG;
			end
			4'b0010: begin
				if (cur_instr[3:2] == 2'b00 && cur_instr[1:0] != 2'b11) begin
					wr = 1'b1;
					mem_size = cur_instr[1:0];
				end
			end
			4'b0100: begin
				if (cur_instr[7:0] == 8'h0b || cur_instr[7:0] == 8'h2b) begin
					last_step = STEP_LAST_BR;
					pcw = first;
					br = first ? BR_UCB : BR_NONE;
				end
			end
			4'b0101: begin
				rd = 1'b1;
				mem_size = MEM_SZ_LONG;
			end
			4'b0110: begin
				if (cur_instr[3:2] == 2'b00 && cur_instr[1:0] != 2'b11) begin
					rd = 1'b1;
					mem_size = cur_instr[1:0];
				end
			end
			4'b1000: begin
				if (cur_instr[11] && cur_instr[8]) begin
					if (first) begin
						pcw = taken;
						br = cur_instr[10] ? BR_DCB : BR_CB;
						last_step = STEP_W'(taken);	// Not taken ends here
					end else begin
						last_step = STEP_LAST_BR;
					end
				end
			end
			4'b1010, 4'b1011: begin	// BRA, BSR
				last_step = STEP_LAST_BR;
				pcw = first;
				br = first ? BR_UCB : BR_NONE;
			end
			default: ;
		endcase
	end

	assign mem_read = step_valid & rd;
	assign mem_write = step_valid & wr;
	assign pc_write = step_valid & pcw;
	assign branch_kind = step_valid ? br : BR_NONE;

endmodule

// ==== sh_operand_dec.sv ====
`timescale 1ns/10ps

module sh_operand_dec
	import sh_dec_pkg::*;
(
	input  logic [INSTR_W-1:0]   cur_instr,
	input  logic [STEP_W-1:0]    step,
	input  logic                 step_valid,
	output logic [REG_NUM_W-1:0] ra_num,
	output logic                 ra_read,
	output logic                 ra_write,
	output logic [REG_NUM_W-1:0] rb_num,
	output logic                 rb_read,
	output logic                 rb_write,
	output imm_kind_e            imm_kind
);

	logic [REG_NUM_W-1:0] rn;
	logic [REG_NUM_W-1:0] rm;
	logic [3:0] en;	// A read, A write, B read, B write
	logic first;

	assign rn = {1'b0, cur_instr[11:8]};
	assign rm = {1'b0, cur_instr[7:4]};
	assign first = (step == STEP_FIRST);

	always_comb begin
		ra_num = rn;
		rb_num = rm;
		en = 4'b0000;
		imm_kind = IMM_ZERO;
		case (cur_instr[15:12])
			4'b0000: begin
				if (cur_instr[11:0] == 12'h00b && first) begin	// RTS
					rb_num = REG_PR;
					en = 4'b0010;
				end
			end
			4'b0001: begin	// MOV.L Rm,@(disp,Rn)
				en = 4'b1010;
				imm_kind = IMM_ZIMM4;
			end
			4'b0010: begin
				case (cur_instr[3:0])
					4'b0000, 4'b0001, 4'b0010, 4'b1000: en = 4'b1010;	// Stores, TST
					4'b1001, 4'b1010, 4'b1011: en = 4'b1110;
					default: ;
				endcase
			end
			4'b0011: begin
				case (cur_instr[3:0])
					4'b0000, 4'b0010, 4'b0011, 4'b0110, 4'b0111: en = 4'b1010;	// CMP/xx
					4'b1000, 4'b1010, 4'b1100, 4'b1110: en = 4'b1110;
					default: ;
				endcase
			end
			4'b0100: begin
				case (cur_instr[7:0])
					8'h00, 8'h01, 8'h04, 8'h05, 8'h20, 8'h21,
					8'h08, 8'h09, 8'h18, 8'h19, 8'h28, 8'h29: en = 4'b1100;	// Shifts
					8'h0b, 8'h2b: begin	// JSR, JMP
						if (first) begin
							rb_num = REG_PR;
							en = {3'b100, ~cur_instr[5]};
						end
					end
					default: ;
				endcase
			end
			4'b0101: begin	// MOV.L @(disp,Rm),Rn
				en = 4'b0110;
				imm_kind = IMM_ZIMM4;
			end
			4'b0110: begin
				case (cur_instr[3:0])
					4'b0100, 4'b0101, 4'b0110: ;	// No post-increment
					default: en = 4'b0110;
				endcase
			end
			4'b0111: begin	// ADD #imm,Rn
				en = 4'b1100;
				imm_kind = IMM_SIMM8;
			end
			4'b1000: begin
				if (cur_instr[11] && cur_instr[8] && first) begin	// BT/BF family
					imm_kind = IMM_SIMM8;
				end
			end
			4'b1010, 4'b1011: begin	// BRA, BSR
				if (first) begin
					rb_num = REG_PR;
					en = {3'b000, cur_instr[12]};
					imm_kind = IMM_SIMM12;
				end
			end
			4'b1100: begin
				if (cur_instr[11:10] == 2'b10) begin	// TST/AND/XOR/OR #imm,R0
					ra_num = REG_R0;
					en = {1'b1, |cur_instr[9:8], 2'b00};
					imm_kind = IMM_ZIMM8;
				end
			end
			4'b1110: begin	// MOV #imm,Rn
				en = 4'b0100;
				imm_kind = IMM_SIMM8;
			end
			default: ;
		endcase
	end

	assign {ra_read, ra_write, rb_read, rb_write} = step_valid ? en : 4'b0000;

endmodule

// ==== sh_step_seq.sv ====
`timescale 1ns/10ps

module sh_step_seq
	import sh_dec_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_req,
	input  logic [INSTR_W-1:0] instr,
	input  logic               t_flag,
	input  logic [STEP_W-1:0]  last_step,
	output logic               instr_ack,
	output logic               step_valid,
	output logic [STEP_W-1:0]  step,
	output logic [INSTR_W-1:0] cur_instr,
	output logic               cur_t
);

	seq_state_e state;
	seq_state_e state_nxt;
	logic [STEP_W-1:0] step_nxt;
	logic accept;

	assign accept = (state == SEQ_IDLE) && instr_req;
	assign step_valid = (state == SEQ_RUN);
	assign instr_ack = (state == SEQ_ACK);

	always_comb begin
		state_nxt = state;
		step_nxt = step;
		case (state)
			SEQ_IDLE: begin
				if (instr_req) begin
					state_nxt = SEQ_RUN;
					step_nxt = STEP_FIRST;
				end
			end
			SEQ_RUN: begin
				if (step >= last_step) begin	// Final step this cycle
					state_nxt = SEQ_ACK;
				end else begin
					step_nxt = step + STEP_W'(1);
				end
			end
			SEQ_ACK: begin
				if (!instr_req) begin	// Ack drops one cycle later
					state_nxt = SEQ_IDLE;
				end
			end
			default: begin
				state_nxt = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			step <= STEP_FIRST;
		end else begin
			state <= state_nxt;
			step <= step_nxt;
		end
	end

	// Instruction and T are held for the whole sequence
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_instr <= instr;
			cur_t <= t_flag;
		end
	end

endmodule

// ==== tb_sh_expect.svh ====
`ifndef TB_SH_EXPECT_SVH
`define TB_SH_EXPECT_SVH

localparam int CLS_RR  = 0;	// Register-register
localparam int CLS_IMM = 1;
localparam int CLS_MEM = 2;
localparam int CLS_UBR = 3;	// BRA, BSR, RTS
localparam int CLS_CBR = 4;	// BT/BF family
localparam int CLS_NOP = 5;

function automatic logic cond_taken(input logic [15:0] ins, input logic t);
	return t == !ins[9];
endfunction

function automatic int expected_steps(input int cls, input logic [15:0] ins, input logic t);
	if (cls == CLS_UBR || (cls == CLS_CBR && cond_taken(ins, t))) begin
		return 2;
	end
	return 1;
endfunction

// Same 2-bit select for Rm,Rn forms and #imm,R0 forms
function automatic logic [3:0] logic_code(input logic [1:0] sel);
	case (sel)
		2'b10: return 4'b0010;	// XOR
		2'b11: return 4'b0100;	// OR
		default: return 4'b0000;
	endcase
endfunction

task automatic set_enables(input logic [3:0] en);	// A rd, A wr, B rd, B wr
	{exp_ra_read, exp_ra_write, exp_rb_read, exp_rb_write} = en;
endtask

task automatic set_alu(input alu_op_e op, input logic [3:0] code);
	exp_alu_op = op;
	exp_alu_code = code;
endtask

task automatic clear_expect(input logic [15:0] ins);
	exp_ra_num = {1'b0, ins[11:8]};
	exp_rb_num = {1'b0, ins[7:4]};
	set_enables(4'b0000);
	exp_imm_kind = IMM_ZERO;
	set_alu(ALU_NOP, 4'b0000);
	exp_alu_sa = 1'b0;
	exp_alu_sb = 1'b0;
	exp_alu_cmp = 3'b000;
	exp_t_write = 1'b0;
	exp_mem_read = 1'b0;
	exp_mem_write = 1'b0;
	exp_mem_size = 2'd0;
	exp_pc_write = 1'b0;
	exp_branch_kind = BR_NONE;
endtask

task automatic build_expect(input int cls, input logic [15:0] ins, input logic t, input int stp);
	logic store;
	store = (ins[15:12] == 4'h1 || ins[15:12] == 4'h2);
	clear_expect(ins);
	case (cls)
		CLS_RR: begin
			if (ins[15:12] == 4'h2) begin
				set_enables(4'b1110);
				set_alu(ALU_LOG, logic_code(ins[1:0]));
			end else if (!ins[3]) begin	// CMP/xx
				set_enables(4'b1010);
				set_alu(ALU_ADD, 4'b0101);
				exp_alu_cmp = ins[2:0];
				exp_t_write = 1'b1;
			end else begin
				set_enables(4'b1110);
				set_alu(ALU_ADD, {3'b000, ins[3:0] == 4'b1000});	// SUB sets bit 0
			end
		end
		CLS_IMM: begin
			exp_alu_sb = 1'b1;	// Immediate enters on the B port
			if (ins[15:12] == 4'hc) begin
				exp_ra_num = REG_R0;
				set_enables({1'b1, ins[9:8] != 2'b00, 2'b00});	// TST only reads
				exp_imm_kind = IMM_ZIMM8;
				set_alu(ALU_LOG, logic_code(ins[9:8]));
				exp_t_write = (ins[9:8] == 2'b00);
			end else begin
				set_enables({ins[15:12] == 4'h7, 3'b100});
				exp_imm_kind = IMM_SIMM8;
				if (ins[15:12] == 4'h7) begin
					set_alu(ALU_ADD, 4'b0000);
				end
			end
		end
		CLS_MEM: begin
			set_enables(store ? 4'b1010 : 4'b0110);
			exp_mem_write = store;
			exp_mem_read = !store;
			set_alu(ALU_ADD, 4'b0000);	// Address adder
			exp_alu_sa = !store;	// Load base is Rm on B
			exp_alu_sb = store;	// Store base is Rn on A
			if (ins[15:12] == 4'h1 || ins[15:12] == 4'h5) begin
				exp_mem_size = 2'd2;
				exp_imm_kind = IMM_ZIMM4;
			end else begin
				exp_mem_size = ins[1:0];
			end
		end
		CLS_UBR: begin
			if (stp == 0) begin
				exp_pc_write = 1'b1;
				exp_branch_kind = BR_UCB;
				exp_rb_num = REG_PR;
				if (ins[15:12] == 4'h0) begin	// RTS
					set_enables(4'b0010);
				end else begin
					set_enables({3'b000, ins[12]});	// BSR saves return address
					exp_imm_kind = IMM_SIMM12;
					set_alu(ALU_ADD, 4'b0000);
					exp_alu_sa = 1'b1;	// PC on the A port
				end
			end
		end
		CLS_CBR: begin
			if (stp == 0) begin
				exp_imm_kind = IMM_SIMM8;
				set_alu(ALU_ADD, 4'b0000);
				exp_alu_sa = 1'b1;
				exp_pc_write = cond_taken(ins, t);
				exp_branch_kind = ins[10] ? BR_DCB : BR_CB;
			end
		end
		default: ;
	endcase
endtask

`endif

// ==== tb_sh_decode.sv ====
`timescale 1ns/10ps

module tb_sh_decode
	import sh_dec_pkg::*;
();

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 10;
	localparam int NUM_TRANSFERS = 36;
	localparam int WATCHDOG_NS   = (NUM_TRANSFERS * 20 + RESET_CYCLES + 10) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic [INSTR_W-1:0] instr;
	logic t_flag;
	logic instr_req;
	logic instr_ack;
	logic step_valid;
	logic [STEP_W-1:0] step;
	logic [REG_NUM_W-1:0] ra_num;
	logic ra_read;
	logic ra_write;
	logic [REG_NUM_W-1:0] rb_num;
	logic rb_read;
	logic rb_write;
	imm_kind_e imm_kind;
	alu_op_e alu_op;
	logic alu_sa;
	logic alu_sb;
	logic [ALU_CODE_W-1:0] alu_code;
	logic [CMP_W-1:0] alu_cmp;
	logic t_write;
	logic mem_read;
	logic mem_write;
	logic [MEM_SZ_W-1:0] mem_size;
	logic pc_write;
	branch_kind_e branch_kind;

	int errors;
	int seed;

	logic [REG_NUM_W-1:0] exp_ra_num;
	logic exp_ra_read;
	logic exp_ra_write;
	logic [REG_NUM_W-1:0] exp_rb_num;
	logic exp_rb_read;
	logic exp_rb_write;
	imm_kind_e exp_imm_kind;
	alu_op_e exp_alu_op;
	logic exp_alu_sa;
	logic exp_alu_sb;
	logic [ALU_CODE_W-1:0] exp_alu_code;
	logic [CMP_W-1:0] exp_alu_cmp;
	logic exp_t_write;
	logic exp_mem_read;
	logic exp_mem_write;
	logic [MEM_SZ_W-1:0] exp_mem_size;
	logic exp_pc_write;
	branch_kind_e exp_branch_kind;

	`include "tb_sh_expect.svh"

	sh_decode_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.t_flag      (t_flag),
		.instr_req   (instr_req),
		.instr_ack   (instr_ack),
		.step_valid  (step_valid),
		.step        (step),
		.ra_num      (ra_num),
		.ra_read     (ra_read),
		.ra_write    (ra_write),
		.rb_num      (rb_num),
		.rb_read     (rb_read),
		.rb_write    (rb_write),
		.imm_kind    (imm_kind),
		.alu_op      (alu_op),
		.alu_sa      (alu_sa),
		.alu_sb      (alu_sb),
		.alu_code    (alu_code),
		.alu_cmp     (alu_cmp),
		.t_write     (t_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_size    (mem_size),
		.pc_write    (pc_write),
		.branch_kind (branch_kind)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: actual 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
		end
	endtask

	function automatic logic [15:0] rand_bits(input logic [15:0] mask);
		return 16'($random(seed)) & mask;
	endfunction

	task automatic compare_outputs(input int stp);
		check_val("step", 32'(step), 32'(stp));
		check_val("ra_read", 32'(ra_read), 32'(exp_ra_read));
		check_val("ra_write", 32'(ra_write), 32'(exp_ra_write));
		check_val("rb_read", 32'(rb_read), 32'(exp_rb_read));
		check_val("rb_write", 32'(rb_write), 32'(exp_rb_write));
		if (exp_ra_read || exp_ra_write) begin
			check_val("ra_num", 32'(ra_num), 32'(exp_ra_num));
		end
		if (exp_rb_read || exp_rb_write) begin
			check_val("rb_num", 32'(rb_num), 32'(exp_rb_num));
		end
		check_val("imm_kind", 32'(imm_kind), 32'(exp_imm_kind));
		check_val("alu_op", 32'(alu_op), 32'(exp_alu_op));
		check_val("alu_sa", 32'(alu_sa), 32'(exp_alu_sa));
		check_val("alu_sb", 32'(alu_sb), 32'(exp_alu_sb));
		if (exp_alu_op != ALU_NOP) begin
			check_val("alu_code", 32'(alu_code), 32'(exp_alu_code));
		end
		check_val("alu_cmp", 32'(alu_cmp), 32'(exp_alu_cmp));
		check_val("t_write", 32'(t_write), 32'(exp_t_write));
		check_val("mem_read", 32'(mem_read), 32'(exp_mem_read));
		check_val("mem_write", 32'(mem_write), 32'(exp_mem_write));
		if (exp_mem_read || exp_mem_write) begin
			check_val("mem_size", 32'(mem_size), 32'(exp_mem_size));
		end
		check_val("pc_write", 32'(pc_write), 32'(exp_pc_write));
		check_val("branch_kind", 32'(branch_kind), 32'(exp_branch_kind));
	endtask

	// Decoder outputs are forced idle while no step is valid
	task automatic check_gated_outputs();
		check_val("ra_read", 32'(ra_read), 32'h0);
		check_val("ra_write", 32'(ra_write), 32'h0);
		check_val("rb_read", 32'(rb_read), 32'h0);
		check_val("rb_write", 32'(rb_write), 32'h0);
		check_val("alu_op", 32'(alu_op), 32'(ALU_NOP));
		check_val("t_write", 32'(t_write), 32'h0);
		check_val("mem_read", 32'(mem_read), 32'h0);
		check_val("mem_write", 32'(mem_write), 32'h0);
		check_val("pc_write", 32'(pc_write), 32'h0);
		check_val("branch_kind", 32'(branch_kind), 32'(BR_NONE));
	endtask

	// Entered and left on a falling edge
	task automatic run_transfer(input int cls, input logic [15:0] ins, input logic t, input int hold);
		int steps;
		int waited;
		steps = 0;
		waited = 0;
		instr = ins;
		t_flag = t;
		instr_req = 1'b1;
		while (!instr_ack && waited < 10) begin
			@(negedge clk);
			waited++;
			if (step_valid) begin
				build_expect(cls, ins, t, steps);
				compare_outputs(steps);
				steps++;
			end
		end
		if (!instr_ack) begin
			errors++;
			$display("ERROR: no acknowledge for instruction %h", ins);
		end else begin
			check_gated_outputs();
		end
		check_val("step count", 32'(steps), 32'(expected_steps(cls, ins, t)));
		check_val("ack latency", 32'(waited), 32'(expected_steps(cls, ins, t) + 1));
		repeat (hold) begin	// Req held past ack
			@(negedge clk);
			check_val("instr_ack", 32'(instr_ack), 32'h1);
			check_val("step_valid", 32'(step_valid), 32'h0);
		end
		instr_req = 1'b0;
		waited = 0;
		while (instr_ack && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (instr_ack) begin
			errors++;
			$display("ERROR: acknowledge stayed high after request dropped, instruction %h", ins);
		end
	endtask

	task automatic handshake_after_reset();
		int hold;
		hold = ($random(seed) & 7) + 1;
		check_val("instr_ack", 32'(instr_ack), 32'h0);
		check_val("step_valid", 32'(step_valid), 32'h0);
		run_transfer(CLS_NOP, 16'hf000 | rand_bits(16'h0fff), 1'b0, hold);	// Unknown opcode
	endtask

	task automatic reg_reg_forms();
		logic [15:0] ops [10];
		ops = '{16'h300c, 16'h3008, 16'h2009, 16'h200a, 16'h200b,
			16'h3000, 16'h3002, 16'h3003, 16'h3006, 16'h3007};	// CMP/xx last
		foreach (ops[i]) begin
			run_transfer(CLS_RR, ops[i] | rand_bits(16'h0ff0), 1'b0, 0);
		end
	endtask

	task automatic immediate_forms();
		logic [15:0] ops [6];
		logic [15:0] mask;
		ops = '{16'h7000, 16'he000, 16'hc800, 16'hc900, 16'hca00, 16'hcb00};
		foreach (ops[i]) begin
			mask = (ops[i][15:12] == 4'hc) ? 16'h00ff : 16'h0fff;
			run_transfer(CLS_IMM, ops[i] | rand_bits(mask), 1'b0, 0);
		end
	endtask

	task automatic load_store_forms();
		logic [15:0] ops [8];
		logic [15:0] mask;
		ops = '{16'h1000, 16'h5000, 16'h2000, 16'h2001, 16'h2002,
			16'h6000, 16'h6001, 16'h6002};
		foreach (ops[i]) begin
			mask = (ops[i][13:12] == 2'b01) ? 16'h0fff : 16'h0ff0;	// Disp forms
			run_transfer(CLS_MEM, ops[i] | rand_bits(mask), 1'b0, 0);
		end
	endtask

	task automatic uncond_branches();
		logic [15:0] ops [3];
		logic [15:0] mask;
		ops = '{16'ha000, 16'hb000, 16'h000b};	// BRA, BSR, RTS
		foreach (ops[i]) begin
			mask = ops[i][15] ? 16'h0fff : 16'h0000;
			run_transfer(CLS_UBR, ops[i] | rand_bits(mask), 1'b0, 0);
		end
	endtask

	task automatic cond_branches();
		logic [15:0] ops [4];
		ops = '{16'h8900, 16'h8b00, 16'h8d00, 16'h8f00};
		foreach (ops[i]) begin
			run_transfer(CLS_CBR, ops[i] | rand_bits(16'h00ff), 1'b0, 0);
			run_transfer(CLS_CBR, ops[i] | rand_bits(16'h00ff), 1'b1, 0);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		errors = 0;
		seed = 32'hcd2f_34ea;
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		t_flag = 1'b0;
		instr_req = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		handshake_after_reset();
		reg_reg_forms();
		immediate_forms();
		load_store_forms();
		uncond_branches();
		cond_branches();
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
